// File: hw/cart_bus_pkg.sv
package cart_bus_pkg;

    // Cartridge edge buses
    typedef logic [7:0]  byte_t;
    typedef logic [14:0] cpu_addr_t;
    typedef logic [13:0] ppu_addr_t;

    // Image layout in cartridge memory
    // PRG occupies 32 KB from the bottom
    localparam logic [15:0] PRG_BASE = 16'h0000;
    // CHR occupies 8 KB right above PRG
    localparam logic [15:0] CHR_BASE = 16'h8000;

    // Value seen by the console while an image is loading
    localparam byte_t OPEN_BUS = 8'hFF;

endpackage

// File: hw/loader_pkg.sv
package loader_pkg;

    // First byte of each SPI frame
    typedef enum logic [7:0] {
        CMD_SET_ADDR   = 8'h01,
        CMD_WRITE      = 8'h02,
        CMD_LOAD_BEGIN = 8'h03,
        CMD_LOAD_END   = 8'h04
    } loader_cmd_t;

    // Command parser states
    typedef enum logic [2:0] {
        ST_OPCODE,
        ST_ADDR_HI,
        ST_ADDR_LO,
        ST_DATA,
        ST_WRITE,
        ST_IGNORE
    } loader_state_t;

endpackage

// File: hw/mem_bus.sv
interface mem_bus import cart_bus_pkg::*; #(
    parameter int MEM_AW = 16
) ();
    logic              req;
    logic              we;
    logic [MEM_AW-1:0] addr;
    byte_t             wdata;
    byte_t             rdata;
    logic              ack;

    modport master (
        output req, we, addr, wdata,
        input  rdata, ack
    );

    modport slave (
        input  req, we, addr, wdata,
        output rdata, ack
    );
endinterface

// File: hw/spi_slave.sv
module spi_slave import cart_bus_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  spi_sck,
    input  logic  spi_cs,
    input  logic  spi_mosi,
    output logic  spi_miso,
    output byte_t rx_byte,
    output logic  rx_valid,
    output logic  cs_active
);
    logic [2:0] sck_sync;
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sck_rise;
    logic       sck_fall;
    logic [2:0] bit_cnt;
    logic [6:0] rx_shift;
    byte_t      tx_shift;

    // Two-flop synchronizers, third SCK stage for edge detect
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sck_sync  <= '0;
            cs_sync   <= '1;
            mosi_sync <= '0;
        end else begin
            sck_sync  <= {sck_sync[1:0], spi_sck};
            cs_sync   <= {cs_sync[0], spi_cs};
            mosi_sync <= {mosi_sync[0], spi_mosi};
        end
    end

    assign sck_rise  = sck_sync[1] & ~sck_sync[2];
    assign sck_fall  = ~sck_sync[1] & sck_sync[2];
    assign cs_active = ~cs_sync[1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
            tx_shift <= '0;
        end else if (!cs_active) begin
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (sck_rise) begin
                bit_cnt  <= bit_cnt + 3'd1;
                rx_valid <= (bit_cnt == 3'd7);
            end
            // Echo path, reload on the last falling edge of a byte
            if (sck_fall) begin
                if (bit_cnt == 3'd0)
                    tx_shift <= rx_byte;
                else
                    tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (cs_active && sck_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7)
                rx_byte <= {rx_shift, mosi_sync[1]};
        end
    end

    assign spi_miso = tx_shift[7];
endmodule

// File: hw/loader_api.sv
module loader_api import cart_bus_pkg::*, loader_pkg::*; #(
    parameter int MEM_AW = 16
) (
    input  logic   clk,
    input  logic   arst_n,
    input  byte_t  rx_byte,
    input  logic   rx_valid,
    input  logic   cs_active,
    output logic   loading,
    mem_bus.master mem
);
    loader_state_t     state;
    byte_t             addr_hi;
    byte_t             wdata_q;
    logic [MEM_AW-1:0] load_addr;
    logic              req_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_OPCODE;
            loading   <= 1'b0;
            req_q     <= 1'b0;
            load_addr <= '0;
        end else if (!cs_active && state != ST_WRITE) begin
            // New frame starts with an opcode
            state <= ST_OPCODE;
        end else begin
            case (state)
                ST_OPCODE: begin
                    if (rx_valid) begin
                        case (loader_cmd_t'(rx_byte))
                            CMD_SET_ADDR: state <= ST_ADDR_HI;
                            CMD_WRITE:    state <= ST_DATA;
                            CMD_LOAD_BEGIN: begin
                                loading <= 1'b1;
                                state   <= ST_IGNORE;
                            end
                            CMD_LOAD_END: begin
                                loading <= 1'b0;
                                state   <= ST_IGNORE;
                            end
                            default: state <= ST_IGNORE;
                        endcase
                    end
                end
                ST_ADDR_HI: begin
                    if (rx_valid)
                        state <= ST_ADDR_LO;
                end
                ST_ADDR_LO: begin
                    if (rx_valid) begin
                        load_addr <= MEM_AW'({addr_hi, rx_byte});
                        state     <= ST_IGNORE;
                    end
                end
                ST_DATA: begin
                    if (rx_valid) begin
                        req_q <= 1'b1;
                        state <= ST_WRITE;
                    end
                end
                // Bytes arriving here are dropped
                ST_WRITE: begin
                    if (mem.ack) begin
                        req_q     <= 1'b0;
                        load_addr <= load_addr + 1'b1;
                        state     <= cs_active ? ST_DATA : ST_OPCODE;
                    end
                end
                default: state <= ST_IGNORE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_ADDR_HI && rx_valid)
            addr_hi <= rx_byte;
        if (state == ST_DATA && rx_valid)
            wdata_q <= rx_byte;
    end

    assign mem.req   = req_q;
    assign mem.we    = 1'b1;
    assign mem.addr  = load_addr;
    assign mem.wdata = wdata_q;
endmodule

// File: hw/mem_arbiter.sv
module mem_arbiter import cart_bus_pkg::*; #(
    parameter int MEM_AW = 16
) (
    input logic   clk,
    input logic   arst_n,
    mem_bus.slave ch_ppu,
    mem_bus.slave ch_cpu,
    mem_bus.slave ch_api
);
    localparam int DEPTH = 2 ** MEM_AW;

    byte_t             mem [DEPTH];
    logic [2:0]        req_vec;
    logic [2:0]        pick;
    logic [2:0]        gnt_q;
    logic [2:0]        ack_q;
    logic              busy_q;
    logic              acc_we;
    logic [MEM_AW-1:0] acc_addr;
    byte_t             acc_wdata;
    byte_t             rdata_q;

    assign req_vec = {ch_api.req, ch_cpu.req, ch_ppu.req};

    // Bit 0 (PPU) wins
    always_comb begin
        pick = 3'b000;
        if (req_vec[0])
            pick = 3'b001;
        else if (req_vec[1])
            pick = 3'b010;
        else if (req_vec[2])
            pick = 3'b100;
    end

    always_comb begin
        if (gnt_q[0]) begin
            acc_we    = ch_ppu.we;
            acc_addr  = ch_ppu.addr;
            acc_wdata = ch_ppu.wdata;
        end else if (gnt_q[1]) begin
            acc_we    = ch_cpu.we;
            acc_addr  = ch_cpu.addr;
            acc_wdata = ch_cpu.wdata;
        end else begin
            acc_we    = ch_api.we;
            acc_addr  = ch_api.addr;
            acc_wdata = ch_api.wdata;
        end
    end

    // Grant, access, ack; no new grant in the ack cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gnt_q  <= '0;
            ack_q  <= '0;
            busy_q <= 1'b0;
        end else begin
            ack_q <= '0;
            if (busy_q) begin
                ack_q  <= gnt_q;
                busy_q <= 1'b0;
            end else if (ack_q == '0 && pick != '0) begin
                gnt_q  <= pick;
                busy_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy_q) begin
            if (acc_we)
                mem[acc_addr] <= acc_wdata;
            rdata_q <= mem[acc_addr];
        end
    end

    assign ch_ppu.rdata = rdata_q;
    assign ch_cpu.rdata = rdata_q;
    assign ch_api.rdata = rdata_q;
    assign ch_ppu.ack   = ack_q[0];
    assign ch_cpu.ack   = ack_q[1];
    assign ch_api.ack   = ack_q[2];
endmodule

// File: hw/prg_fetch.sv
module prg_fetch import cart_bus_pkg::*; #(
    parameter int MEM_AW = 16
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      en,
    input  logic      m2,
    input  logic      romsel,
    input  logic      cpu_rw,
    input  cpu_addr_t cpu_addr,
    output byte_t     cpu_data,
    mem_bus.master    mem
);
    logic [2:0]        m2_sync;
    logic              m2_rise;
    logic              start;
    logic              req_q;
    logic [MEM_AW-1:0] addr_q;
    byte_t             data_q;

    assign m2_rise = m2_sync[1] & ~m2_sync[2];
    // ROM read cycle only
    assign start   = m2_rise && !romsel && cpu_rw && en && !req_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m2_sync <= '0;
            req_q   <= 1'b0;
        end else begin
            m2_sync <= {m2_sync[1:0], m2};
            if (mem.ack)
                req_q <= 1'b0;
            else if (start)
                req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            addr_q <= MEM_AW'(PRG_BASE + 16'(cpu_addr));
        if (mem.ack)
            data_q <= mem.rdata;
    end

    assign cpu_data  = en ? data_q : OPEN_BUS;
    assign mem.req   = req_q;
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;
endmodule

// File: hw/chr_fetch.sv
module chr_fetch import cart_bus_pkg::*; #(
    parameter int MEM_AW = 16
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      en,
    input  logic      ppu_rd,
    input  ppu_addr_t ppu_addr,
    output byte_t     ppu_data,
    output logic      ciram_ce,
    output logic      ciram_a10,
    mem_bus.master    mem
);
    logic [2:0]        rd_sync;
    logic              rd_fall;
    logic              start;
    logic              req_q;
    logic [MEM_AW-1:0] addr_q;
    byte_t             data_q;

    // Read strobe is active low
    assign rd_fall = ~rd_sync[1] & rd_sync[2];
    assign start   = rd_fall && !ppu_addr[13] && en && !req_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_sync <= '1;
            req_q   <= 1'b0;
        end else begin
            rd_sync <= {rd_sync[1:0], ppu_rd};
            if (mem.ack)
                req_q <= 1'b0;
            else if (start)
                req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            addr_q <= MEM_AW'(CHR_BASE + 16'(ppu_addr[12:0]));
        if (mem.ack)
            data_q <= mem.rdata;
    end

    // Nametables in console RAM, vertical mirroring
    assign ciram_ce  = !ppu_addr[13];
    assign ciram_a10 = ppu_addr[10];

    assign ppu_data  = en ? data_q : OPEN_BUS;
    assign mem.req   = req_q;
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;
endmodule

// File: hw/fcart_top.sv
module fcart_top import cart_bus_pkg::*; #(
    parameter int MEM_AW = 16
) (
    input  logic      clk,
    input  logic      arst_n,

    // SPI link to the host
    input  logic      spi_sck,
    input  logic      spi_cs,
    input  logic      spi_mosi,
    output logic      spi_miso,

    // CPU side
    input  logic      m2,
    input  logic      romsel,
    input  logic      cpu_rw,
    input  cpu_addr_t cpu_addr,
    output byte_t     cpu_data,
    output logic      cpu_dir,

    // PPU side
    input  logic      ppu_rd,
    input  ppu_addr_t ppu_addr,
    output byte_t     ppu_data,
    output logic      ppu_dir,
    output logic      ciram_ce,
    output logic      ciram_a10,

    output logic      loading
);
    logic  fetch_en;
    byte_t rx_byte;
    logic  rx_valid;
    logic  cs_active;

    mem_bus #(.MEM_AW(MEM_AW)) ch_ppu ();
    mem_bus #(.MEM_AW(MEM_AW)) ch_cpu ();
    mem_bus #(.MEM_AW(MEM_AW)) ch_api ();

    // Console sees open bus while the host rewrites the image
    assign fetch_en = !loading;

    // Level shifter direction, towards the console during a read
    assign cpu_dir = !romsel && cpu_rw && m2;
    assign ppu_dir = !ppu_addr[13] && !ppu_rd;

    spi_slave u_spi_slave (
        .clk      (clk),
        .arst_n   (arst_n),
        .spi_sck  (spi_sck),
        .spi_cs   (spi_cs),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .cs_active(cs_active)
    );

    loader_api #(.MEM_AW(MEM_AW)) u_loader_api (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .cs_active(cs_active),
        .loading  (loading),
        .mem      (ch_api.master)
    );

    mem_arbiter #(.MEM_AW(MEM_AW)) u_mem_arbiter (
        .clk   (clk),
        .arst_n(arst_n),
        .ch_ppu(ch_ppu.slave),
        .ch_cpu(ch_cpu.slave),
        .ch_api(ch_api.slave)
    );

    prg_fetch #(.MEM_AW(MEM_AW)) u_prg_fetch (
        .clk     (clk),
        .arst_n  (arst_n),
        .en      (fetch_en),
        .m2      (m2),
        .romsel  (romsel),
        .cpu_rw  (cpu_rw),
        .cpu_addr(cpu_addr),
        .cpu_data(cpu_data),
        .mem     (ch_cpu.master)
    );

    chr_fetch #(.MEM_AW(MEM_AW)) u_chr_fetch (
        .clk      (clk),
        .arst_n   (arst_n),
        .en       (fetch_en),
        .ppu_rd   (ppu_rd),
        .ppu_addr (ppu_addr),
        .ppu_data (ppu_data),
        .ciram_ce (ciram_ce),
        .ciram_a10(ciram_a10),
        .mem      (ch_ppu.master)
    );
endmodule

// File: tests/tb_clock.sv
module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released just after an edge, in step with the other stimulus
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end
endmodule

// File: tests/fcart_chk.sv
module fcart_chk (
    input logic       clk,
    input logic       arst_n,
    input logic [2:0] req,
    input logic [2:0] ack,
    input logic       en
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count;

    initial fail_count = 0;

    a_one_ack: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(ack))
    else begin
        $error("more than one ack in the same cycle");
        fail_count++;
    end

    // Ack only on a channel that is still requesting
    a_ack_req: assert property (@(posedge clk) disable iff (!arst_n) (ack & ~req) == 3'b000)
    else begin
        $error("ack without a pending request");
        fail_count++;
    end

    a_req_en: assert property (@(posedge clk) disable iff (!arst_n) req[0] |-> en)
    else begin
        $error("fetch request pending while loading");
        fail_count++;
    end
endmodule

bind mem_arbiter fcart_chk u_arb_chk (
    .clk   (clk),
    .arst_n(arst_n),
    .req   (req_vec),
    .ack   (ack_q),
    .en    (1'b1)
);

bind prg_fetch fcart_chk u_prg_chk (
    .clk   (clk),
    .arst_n(arst_n),
    .req   ({2'b00, req_q}),
    .ack   (3'b000),
    .en    (en)
);

bind chr_fetch fcart_chk u_chr_chk (
    .clk   (clk),
    .arst_n(arst_n),
    .req   ({2'b00, req_q}),
    .ack   (3'b000),
    .en    (en)
);

// File: tests/fcart_tb.sv
module fcart_tb import cart_bus_pkg::*, loader_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_SCK = 6;
    localparam int WINDOW   = 16;
    localparam int TIMEOUT  = 2000;
    localparam int N_CASES  = 9;
    localparam int N_PAIRS  = 3;

    logic      clk;
    logic      arst_n;
    logic      spi_sck;
    logic      spi_cs;
    logic      spi_mosi;
    logic      spi_miso;
    logic      m2;
    logic      romsel;
    logic      cpu_rw;
    cpu_addr_t cpu_addr;
    byte_t     cpu_data;
    logic      cpu_dir;
    logic      ppu_rd;
    ppu_addr_t ppu_addr;
    byte_t     ppu_data;
    logic      ppu_dir;
    logic      ciram_ce;
    logic      ciram_a10;
    logic      loading;

    int          seed;
    int          n_pass;
    int          n_fail;
    int unsigned n_assert;
    byte_t       last_tx;
    byte_t       shadow [65536];

    // Read table, expected bytes are filled in from the shadow image
    string       case_name [N_CASES];
    bit          case_chr  [N_CASES];
    logic [15:0] case_addr [N_CASES];
    byte_t       case_exp  [N_CASES];
    int          pair_cpu  [N_PAIRS] = '{1, 4, 0};
    int          pair_ppu  [N_PAIRS] = '{6, 8, 7};

    byte_t rd_data;
    byte_t rd_data2;
    logic  rd_dir;
    logic  rd_ce;
    logic  rd_a10;

    tb_clock u_tb_clock (
        .clk   (clk),
        .arst_n(arst_n)
    );

    fcart_top #(.MEM_AW(16)) u_fcart_top (
        .clk      (clk),
        .arst_n   (arst_n),
        .spi_sck  (spi_sck),
        .spi_cs   (spi_cs),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .m2       (m2),
        .romsel   (romsel),
        .cpu_rw   (cpu_rw),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .cpu_dir  (cpu_dir),
        .ppu_rd   (ppu_rd),
        .ppu_addr (ppu_addr),
        .ppu_data (ppu_data),
        .ppu_dir  (ppu_dir),
        .ciram_ce (ciram_ce),
        .ciram_a10(ciram_a10),
        .loading  (loading)
    );

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act === exp) begin
            n_pass++;
            $display("[PASS] %s value %h", name, act);
        end else begin
            n_fail++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act === exp) begin
            n_pass++;
            $display("[PASS] %s value %b", name, act);
        end else begin
            n_fail++;
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic wait_reset_done();
        int n;
        n = 0;
        while (arst_n !== 1'b1 && n < TIMEOUT) begin
            step(1);
            n++;
        end
        if (arst_n !== 1'b1) begin
            $display("timeout waiting for reset release");
            n_fail++;
        end
    endtask

    task automatic wait_loading(input logic level);
        int n;
        n = 0;
        while (loading !== level && n < TIMEOUT) begin
            step(1);
            n++;
        end
        if (loading !== level) begin
            $display("timeout waiting for loading to go %0b", level);
            n_fail++;
        end
    endtask

    task automatic set_case(input int i, input string name, input bit chr,
                            input logic [15:0] addr);
        case_name[i] = name;
        case_chr[i]  = chr;
        case_addr[i] = addr;
    endtask

    // Where a console address lands in cartridge memory
    function automatic logic [15:0] image_addr(input bit chr, input logic [15:0] a);
        if (chr)
            return CHR_BASE + {3'b000, a[12:0]};
        return PRG_BASE + {1'b0, a[14:0]};
    endfunction

    // Mode 0, MISO carries the byte sent before this one
    task automatic send_byte(input byte_t b);
        byte_t echo;
        for (int i = 7; i >= 0; i--) begin
            spi_mosi = b[i];
            step(HALF_SCK);
            echo[i] = spi_miso;
            spi_sck = 1'b1;
            step(HALF_SCK);
            spi_sck = 1'b0;
        end
        check_byte("spi_echo", last_tx, echo);
        last_tx = b;
    endtask

    task automatic begin_frame();
        step(1);
        spi_cs = 1'b0;
        step(HALF_SCK);
    endtask

    task automatic end_frame();
        step(HALF_SCK);
        spi_cs = 1'b1;
        step(8);
    endtask

    task automatic send_cmd(input loader_cmd_t cmd);
        begin_frame();
        send_byte(byte_t'(cmd));
        end_frame();
    endtask

    task automatic load_block(input logic [15:0] base, input int count);
        byte_t b;
        begin_frame();
        send_byte(byte_t'(CMD_SET_ADDR));
        send_byte(base[15:8]);
        send_byte(base[7:0]);
        end_frame();
        begin_frame();
        send_byte(byte_t'(CMD_WRITE));
        for (int i = 0; i < count; i++) begin
            b = byte_t'($random(seed));
            shadow[16'(base + i)] = b;
            send_byte(b);
        end
        end_frame();
    endtask

    task automatic cpu_read(input logic [15:0] a, input logic rs, input logic rw,
                            output byte_t data, output logic dir);
        cpu_addr = cpu_addr_t'(a);
        romsel   = rs;
        cpu_rw   = rw;
        step(2);
        m2 = 1'b1;
        step(WINDOW);
        data   = cpu_data;
        dir    = cpu_dir;
        m2     = 1'b0;
        romsel = 1'b1;
        cpu_rw = 1'b1;
        step(4);
    endtask

    task automatic ppu_read(input logic [15:0] a, output byte_t data, output logic dir,
                            output logic ce, output logic a10);
        ppu_addr = ppu_addr_t'(a);
        step(2);
        ppu_rd = 1'b0;
        step(WINDOW);
        data   = ppu_data;
        dir    = ppu_dir;
        ce     = ciram_ce;
        a10    = ciram_a10;
        ppu_rd = 1'b1;
        step(4);
    endtask

    // Both strobes in the same cycle so the arbiter has to queue one
    task automatic dual_read(input logic [15:0] ca, input logic [15:0] pa,
                             output byte_t cd, output byte_t pd);
        cpu_addr = cpu_addr_t'(ca);
        ppu_addr = ppu_addr_t'(pa);
        romsel   = 1'b0;
        cpu_rw   = 1'b1;
        step(2);
        m2     = 1'b1;
        ppu_rd = 1'b0;
        step(WINDOW);
        cd     = cpu_data;
        pd     = ppu_data;
        m2     = 1'b0;
        ppu_rd = 1'b1;
        romsel = 1'b1;
        step(4);
    endtask

    initial begin
        spi_sck  = 1'b0;
        spi_cs   = 1'b1;
        spi_mosi = 1'b0;
        m2       = 1'b0;
        romsel   = 1'b1;
        cpu_rw   = 1'b1;
        cpu_addr = '0;
        ppu_rd   = 1'b1;
        ppu_addr = '0;
        seed     = 86584;
        n_pass   = 0;
        n_fail   = 0;
        last_tx  = 8'h00;

        set_case(0, "prg_first",    1'b0, 16'h0000);
        set_case(1, "prg_mid",      1'b0, 16'h0005);
        set_case(2, "prg_block_end", 1'b0, 16'h0007);
        set_case(3, "prg_top_near", 1'b0, 16'h7FFA);
        set_case(4, "prg_top",      1'b0, 16'h7FFF);
        set_case(5, "chr_first",    1'b1, 16'h0000);
        set_case(6, "chr_mid",      1'b1, 16'h0003);
        set_case(7, "chr_a10",      1'b1, 16'h0402);
        set_case(8, "chr_a10_end",  1'b1, 16'h0407);

        wait_reset_done();
        step(2);
        check_bit("reset_loading", 1'b0, loading);
        check_bit("reset_miso", 1'b0, spi_miso);

        send_cmd(CMD_LOAD_BEGIN);
        wait_loading(1'b1);
        check_bit("load_begin", 1'b1, loading);
        load_block(PRG_BASE, 8);
        load_block(PRG_BASE + 16'h7FF8, 8);
        load_block(CHR_BASE, 8);
        load_block(CHR_BASE + 16'h0400, 8);
        cpu_read(16'h0000, 1'b0, 1'b1, rd_data, rd_dir);
        check_byte("load_open_bus", OPEN_BUS, rd_data);
        send_cmd(CMD_LOAD_END);
        wait_loading(1'b0);
        check_bit("load_end", 1'b0, loading);

        for (int i = 0; i < N_CASES; i++)
            case_exp[i] = shadow[image_addr(case_chr[i], case_addr[i])];

        for (int i = 0; i < N_CASES; i++) begin
            if (!case_chr[i]) begin
                cpu_read(case_addr[i], 1'b0, 1'b1, rd_data, rd_dir);
                check_byte(case_name[i], case_exp[i], rd_data);
                check_bit({case_name[i], "_dir"}, 1'b1, rd_dir);
            end else begin
                ppu_read(case_addr[i], rd_data, rd_dir, rd_ce, rd_a10);
                check_byte(case_name[i], case_exp[i], rd_data);
                check_bit({case_name[i], "_dir"}, 1'b1, rd_dir);
                check_bit({case_name[i], "_ce"}, 1'b1, rd_ce);
                check_bit({case_name[i], "_a10"}, case_addr[i][10], rd_a10);
            end
        end

        // Console must not see the cartridge driving
        cpu_read(16'h0005, 1'b1, 1'b1, rd_data, rd_dir);
        check_bit("nodrive_romsel_dir", 1'b0, rd_dir);
        cpu_read(16'h0005, 1'b0, 1'b0, rd_data, rd_dir);
        check_bit("nodrive_write_dir", 1'b0, rd_dir);
        ppu_read(16'h2403, rd_data, rd_dir, rd_ce, rd_a10);
        check_bit("nodrive_ppu_dir", 1'b0, rd_dir);
        check_bit("nodrive_ciram_ce", 1'b0, rd_ce);

        for (int k = 0; k < N_PAIRS; k++) begin
            dual_read(case_addr[pair_cpu[k]], case_addr[pair_ppu[k]], rd_data, rd_data2);
            check_byte({"contend_", case_name[pair_cpu[k]]}, case_exp[pair_cpu[k]], rd_data);
            check_byte({"contend_", case_name[pair_ppu[k]]}, case_exp[pair_ppu[k]], rd_data2);
        end

        n_assert = u_fcart_top.u_mem_arbiter.u_arb_chk.fail_count
                 + u_fcart_top.u_prg_fetch.u_prg_chk.fail_count
                 + u_fcart_top.u_chr_fetch.u_chr_chk.fail_count;
        if (n_assert != 0) begin
            $display("bound assertions failed %0d times", n_assert);
            n_fail += int'(n_assert);
        end

        $display("Checks passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end
endmodule

// File: compile.f
hw/cart_bus_pkg.sv
hw/loader_pkg.sv
hw/mem_bus.sv
hw/spi_slave.sv
hw/loader_api.sv
hw/mem_arbiter.sv
hw/prg_fetch.sv
hw/chr_fetch.sv
hw/fcart_top.sv
tests/tb_clock.sv
tests/fcart_chk.sv
tests/fcart_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fcart_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation finished: PASS
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
